// File: csr_pkg.sv
package csr_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths and basic types
    //////////////////////////////////////////////////////////////////////
    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [11:0] csr_addr_t;

    typedef enum logic [1:0] {
        priv_u = 2'd0,
        priv_s = 2'd1,
        priv_m = 2'd3
    } priv_mode_t;

    //////////////////////////////////////////////////////////////////////
    // csr addresses
    //////////////////////////////////////////////////////////////////////
    // unprivileged counter views
    localparam csr_addr_t csr_cycle         = 12'hc00;
    localparam csr_addr_t csr_cycleh        = 12'hc80;
    localparam csr_addr_t csr_instret       = 12'hc02;
    localparam csr_addr_t csr_instreth      = 12'hc82;
    // machine identification
    localparam csr_addr_t csr_misa          = 12'h301;
    localparam csr_addr_t csr_mvendorid     = 12'hf11;
    localparam csr_addr_t csr_marchid       = 12'hf12;
    localparam csr_addr_t csr_mimpid        = 12'hf13;
    localparam csr_addr_t csr_mhartid       = 12'hf14;
    // machine trap setup and handling
    localparam csr_addr_t csr_mstatus       = 12'h300;
    localparam csr_addr_t csr_mtvec         = 12'h305;
    localparam csr_addr_t csr_mip           = 12'h344;
    localparam csr_addr_t csr_mie           = 12'h304;
    localparam csr_addr_t csr_mscratch      = 12'h340;
    localparam csr_addr_t csr_mepc          = 12'h341;
    localparam csr_addr_t csr_mcause        = 12'h342;
    localparam csr_addr_t csr_mtval         = 12'h343;
    // machine counters
    localparam csr_addr_t csr_mcycle        = 12'hb00;
    localparam csr_addr_t csr_mcycleh       = 12'hb80;
    localparam csr_addr_t csr_minstret      = 12'hb02;
    localparam csr_addr_t csr_minstreth     = 12'hb82;
    localparam csr_addr_t csr_mcountinhibit = 12'h320;

    //////////////////////////////////////////////////////////////////////
    // fixed values and field positions
    //////////////////////////////////////////////////////////////////////
    // mxl = 1 (rv32), i extension only
    localparam word_t misa_value   = 32'h4000_0100;
    localparam word_t mimpid_value = 32'h0000_0002;

    localparam logic [1:0] mtvec_mode_direct   = 2'd0;
    localparam logic [1:0] mtvec_mode_vectored = 2'd1;
    localparam int mtvec_align_bits = 7;

    localparam int mstatus_mie_bit  = 3;
    localparam int mstatus_mpie_bit = 7;
    localparam int mstatus_mpp_lsb  = 11;
    localparam int mstatus_mpp_msb  = 12;

    localparam int int_mti_bit      = 7;
    localparam int int_platform_lsb = 16;

    //////////////////////////////////////////////////////////////////////
    // port structs
    //////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic      en;
        csr_addr_t addr;
        word_t     data;
    } csr_write_t;

    typedef struct packed {
        logic  insert;
        logic  is_mret;
        word_t epc;
        word_t cause;
        word_t val;
    } trap_req_t;

    // writable mstatus fields only
    typedef struct packed {
        priv_mode_t mpp;
        logic       mpie;
        logic       mie;
    } mstatus_t;

endpackage

// File: csr_counters.sv
`timescale 1ns/1ps

module csr_counters (
    input  logic                clk,
    input  logic                rst_n,
    input  csr_pkg::csr_write_t wr,
    input  logic                retire,
    output logic [63:0]         mcycle,
    output logic [63:0]         minstret,
    output csr_pkg::word_t      mcountinhibit
);
    import csr_pkg::*;

    // stored inhibit bits, cy and ir
    logic cy_inhibit;
    logic ir_inhibit;
    logic wr_ok;

    assign wr_ok = wr.en & retire;

    // hpm inhibit bits are not implemented and read as zero
    assign mcountinhibit = {{(xlen - 3){1'b0}}, ir_inhibit, 1'b0, cy_inhibit};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mcycle     <= '0;
            minstret   <= '0;
            cy_inhibit <= 1'b0;
            ir_inhibit <= 1'b0;
        end else begin
            // a half-word write takes the place of the increment
            if (wr_ok && wr.addr == csr_mcycle) begin
                mcycle[31:0] <= wr.data;
            end else if (wr_ok && wr.addr == csr_mcycleh) begin
                mcycle[63:32] <= wr.data;
            end else if (!cy_inhibit) begin
                mcycle <= mcycle + 64'd1;
            end

            if (wr_ok && wr.addr == csr_minstret) begin
                minstret[31:0] <= wr.data;
            end else if (wr_ok && wr.addr == csr_minstreth) begin
                minstret[63:32] <= wr.data;
            end else if (retire && !ir_inhibit) begin
                minstret <= minstret + 64'd1;
            end

            if (wr_ok && wr.addr == csr_mcountinhibit) begin
                cy_inhibit <= wr.data[0];
                ir_inhibit <= wr.data[2];
            end
        end
    end

endmodule

// File: csr_trap_state.sv
`timescale 1ns/1ps

module csr_trap_state (
    input  logic                clk,
    input  logic                rst_n,
    input  csr_pkg::csr_write_t wr,
    input  logic                retire,
    input  csr_pkg::trap_req_t  trap,
    output csr_pkg::priv_mode_t priv,
    output csr_pkg::mstatus_t   mstatus,
    output csr_pkg::word_t      mtvec,
    output csr_pkg::word_t      mepc,
    output csr_pkg::word_t      mcause,
    output csr_pkg::word_t      mtval,
    output csr_pkg::word_t      mscratch
);
    import csr_pkg::*;

    logic wr_ok;

    assign wr_ok = wr.en & retire;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            priv         <= priv_m;
            mstatus.mpp  <= priv_u;
            mstatus.mpie <= 1'b1;
            mstatus.mie  <= 1'b1;
            mtvec        <= '0;
            mepc         <= '0;
            mcause       <= '0;
            mtval        <= '0;
            mscratch     <= '0;
        end else begin
            //////////////////////////////////////////////////////////////////////
            // csr writes, legalized
            //////////////////////////////////////////////////////////////////////
            if (wr_ok) begin
                case (wr.addr)
                    csr_mstatus: begin
                        // only m and u exist, anything else drops to u
                        if (wr.data[mstatus_mpp_msb:mstatus_mpp_lsb] == priv_m) begin
                            mstatus.mpp <= priv_m;
                        end else begin
                            mstatus.mpp <= priv_u;
                        end
                        mstatus.mpie <= wr.data[mstatus_mpie_bit];
                        mstatus.mie  <= wr.data[mstatus_mie_bit];
                    end
                    csr_mtvec: begin
                        if (wr.data[1:0] == mtvec_mode_vectored) begin
                            mtvec <= {wr.data[xlen-1:mtvec_align_bits],
                                      {(mtvec_align_bits - 2){1'b0}},
                                      mtvec_mode_vectored};
                        end else begin
                            // reserved modes fall back to direct
                            mtvec <= {wr.data[xlen-1:2], mtvec_mode_direct};
                        end
                    end
                    csr_mepc:     mepc     <= {wr.data[xlen-1:2], 2'b00};
                    csr_mcause:   mcause   <= wr.data;
                    csr_mtval:    mtval    <= wr.data;
                    csr_mscratch: mscratch <= wr.data;
                    default: ;
                endcase
            end

            //////////////////////////////////////////////////////////////////////
            // trap entry and mret, last assignment wins over the write
            //////////////////////////////////////////////////////////////////////
            if (trap.insert) begin
                if (trap.is_mret) begin
                    priv         <= mstatus.mpp;
                    mstatus.mie  <= mstatus.mpie;
                    mstatus.mpie <= 1'b1;
                    mstatus.mpp  <= priv_u;
                end else begin
                    priv         <= priv_m;
                    mstatus.mpie <= mstatus.mie;
                    mstatus.mie  <= 1'b0;
                    mstatus.mpp  <= priv;
                    mepc         <= trap.epc;
                    mcause       <= trap.cause;
                    mtval        <= trap.val;
                end
            end
        end
    end

endmodule

// File: csr_interrupts.sv
`timescale 1ns/1ps

module csr_interrupts (
    input  logic                clk,
    input  logic                rst_n,
    input  csr_pkg::csr_write_t wr,
    input  logic                retire,
    input  csr_pkg::priv_mode_t priv,
    input  logic                global_ie,
    input  logic                mtime_interrupt,
    input  csr_pkg::word_t      int_sources,
    output csr_pkg::word_t      mip,
    output csr_pkg::word_t      mie,
    output csr_pkg::word_t      interrupts
);
    import csr_pkg::*;

    logic [xlen-1:int_platform_lsb] platform_pend;
    logic [xlen-1:int_platform_lsb] platform_en;
    logic                           mti_en;
    logic                           wr_ok;
    word_t                          pending_masked;

    assign wr_ok = wr.en & retire;

    // platform pending bits are sticky, a mip write replaces the held value
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            platform_pend <= '0;
            platform_en   <= '0;
            mti_en        <= 1'b0;
        end else begin
            if (wr_ok && wr.addr == csr_mip) begin
                platform_pend <= wr.data[xlen-1:int_platform_lsb]
                               | int_sources[xlen-1:int_platform_lsb];
            end else begin
                platform_pend <= platform_pend | int_sources[xlen-1:int_platform_lsb];
            end
            if (wr_ok && wr.addr == csr_mie) begin
                platform_en <= wr.data[xlen-1:int_platform_lsb];
                mti_en      <= wr.data[int_mti_bit];
            end
        end
    end

    always_comb begin
        mip = '0;
        mip[int_mti_bit] = mtime_interrupt;
        mip[xlen-1:int_platform_lsb] = platform_pend;
        mie = '0;
        mie[int_mti_bit] = mti_en;
        mie[xlen-1:int_platform_lsb] = platform_en;
    end

    assign pending_masked = mip & mie;

    // m mode honors mstatus.mie, lower modes always see enabled sources
    always_comb begin
        if (!rst_n) begin
            interrupts = '0;
        end else if (priv == priv_m && !global_ie) begin
            interrupts = '0;
        end else begin
            interrupts = pending_masked;
        end
    end

endmodule

// File: csr_read_mux.sv
`timescale 1ns/1ps

module csr_read_mux #(
    parameter int unsigned hart_id = 0
) (
    input  logic                rst_n,
    input  csr_pkg::priv_mode_t priv,
    input  csr_pkg::csr_addr_t  rd_addr,
    input  csr_pkg::mstatus_t   mstatus,
    input  csr_pkg::word_t      mtvec,
    input  csr_pkg::word_t      mepc,
    input  csr_pkg::word_t      mcause,
    input  csr_pkg::word_t      mtval,
    input  csr_pkg::word_t      mscratch,
    input  csr_pkg::word_t      mip,
    input  csr_pkg::word_t      mie,
    input  logic [63:0]         mcycle,
    input  logic [63:0]         minstret,
    input  csr_pkg::word_t      mcountinhibit,
    output csr_pkg::word_t      rd_data,
    output logic                illegal
);
    import csr_pkg::*;

    word_t mstatus_word;
    word_t sel_data;
    logic  known;
    logic  machine_only;
    logic  legal;

    // place the writable fields at their architectural positions
    always_comb begin
        mstatus_word = '0;
        mstatus_word[mstatus_mie_bit]  = mstatus.mie;
        mstatus_word[mstatus_mpie_bit] = mstatus.mpie;
        mstatus_word[mstatus_mpp_msb:mstatus_mpp_lsb] = mstatus.mpp;
    end

    //////////////////////////////////////////////////////////////////////
    // address decode
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        sel_data     = '0;
        known        = 1'b1;
        machine_only = 1'b1;
        case (rd_addr)
            // readable from any mode
            csr_cycle: begin
                machine_only = 1'b0;
                sel_data     = mcycle[31:0];
            end
            csr_cycleh: begin
                machine_only = 1'b0;
                sel_data     = mcycle[63:32];
            end
            csr_instret: begin
                machine_only = 1'b0;
                sel_data     = minstret[31:0];
            end
            csr_instreth: begin
                machine_only = 1'b0;
                sel_data     = minstret[63:32];
            end
            // machine mode only
            csr_misa:          sel_data = misa_value;
            csr_mvendorid:     sel_data = '0;
            csr_marchid:       sel_data = '0;
            csr_mimpid:        sel_data = mimpid_value;
            csr_mhartid:       sel_data = word_t'(hart_id);
            csr_mstatus:       sel_data = mstatus_word;
            csr_mtvec:         sel_data = mtvec;
            csr_mip:           sel_data = mip;
            csr_mie:           sel_data = mie;
            csr_mscratch:      sel_data = mscratch;
            csr_mepc:          sel_data = mepc;
            csr_mcause:        sel_data = mcause;
            csr_mtval:         sel_data = mtval;
            csr_mcycle:        sel_data = mcycle[31:0];
            csr_mcycleh:       sel_data = mcycle[63:32];
            csr_minstret:      sel_data = minstret[31:0];
            csr_minstreth:     sel_data = minstret[63:32];
            csr_mcountinhibit: sel_data = mcountinhibit;
            default:           known    = 1'b0;
        endcase
    end

    assign legal   = known && (!machine_only || priv == priv_m);
    // nothing flagged during reset
    assign illegal = rst_n && !legal;
    assign rd_data = (rst_n && legal) ? sel_data : '0;

endmodule

// File: csr_unit.sv
`timescale 1ns/1ps

module csr_unit #(
    parameter int unsigned hart_id = 0
) (
    input  logic                clk,
    input  logic                rst_n,
    input  csr_pkg::csr_write_t wr,
    input  logic                retire,
    input  csr_pkg::trap_req_t  trap,
    input  csr_pkg::csr_addr_t  rd_addr,
    input  logic                mtime_interrupt,
    input  csr_pkg::word_t      int_sources,
    output csr_pkg::word_t      rd_data,
    output logic                illegal,
    output csr_pkg::word_t      interrupts,
    output csr_pkg::word_t      mepc,
    output csr_pkg::word_t      mtvec
);
    import csr_pkg::*;

    priv_mode_t  priv;
    mstatus_t    mstatus;
    csr_write_t  wr_m;
    word_t       mcause;
    word_t       mtval;
    word_t       mscratch;
    word_t       mip;
    word_t       mie;
    word_t       mcountinhibit;
    logic [63:0] mcycle;
    logic [63:0] minstret;

    // all writable csrs are machine level, writes from u mode are dropped
    assign wr_m = '{en: wr.en & (priv == priv_m), addr: wr.addr, data: wr.data};

    //////////////////////////////////////////////////////////////////////
    // register blocks
    //////////////////////////////////////////////////////////////////////
    csr_counters u_counters (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr            (wr_m),
        .retire        (retire),
        .mcycle        (mcycle),
        .minstret      (minstret),
        .mcountinhibit (mcountinhibit)
    );

    csr_trap_state u_trap_state (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr       (wr_m),
        .retire   (retire),
        .trap     (trap),
        .priv     (priv),
        .mstatus  (mstatus),
        .mtvec    (mtvec),
        .mepc     (mepc),
        .mcause   (mcause),
        .mtval    (mtval),
        .mscratch (mscratch)
    );

    csr_interrupts u_interrupts (
        .clk             (clk),
        .rst_n           (rst_n),
        .wr              (wr_m),
        .retire          (retire),
        .priv            (priv),
        .global_ie       (mstatus.mie),
        .mtime_interrupt (mtime_interrupt),
        .int_sources     (int_sources),
        .mip             (mip),
        .mie             (mie),
        .interrupts      (interrupts)
    );

    //////////////////////////////////////////////////////////////////////
    // read path
    //////////////////////////////////////////////////////////////////////
    csr_read_mux #(
        .hart_id (hart_id)
    ) u_read_mux (
        .rst_n         (rst_n),
        .priv          (priv),
        .rd_addr       (rd_addr),
        .mstatus       (mstatus),
        .mtvec         (mtvec),
        .mepc          (mepc),
        .mcause        (mcause),
        .mtval         (mtval),
        .mscratch      (mscratch),
        .mip           (mip),
        .mie           (mie),
        .mcycle        (mcycle),
        .minstret      (minstret),
        .mcountinhibit (mcountinhibit),
        .rd_data       (rd_data),
        .illegal       (illegal)
    );

endmodule

// File: csr_unit_chk.sv
`timescale 1ns/1ps

module csr_unit_chk (
    input logic                clk,
    input logic                rst_n,
    input csr_pkg::word_t      rd_data,
    input logic                illegal,
    input csr_pkg::word_t      interrupts,
    input csr_pkg::priv_mode_t priv
);
    import csr_pkg::*;

    // failure count, summed into the testbench summary
    int assert_fails = 0;

    illegal_reads_zero: assert property (@(posedge clk) illegal |-> rd_data == '0)
        else begin
            $error("illegal read returned nonzero data");
            assert_fails++;
        end

    quiet_in_reset: assert property (@(posedge clk) !rst_n |-> interrupts == '0)
        else begin
            $error("interrupts active during reset");
            assert_fails++;
        end

    no_supervisor: assert property (@(posedge clk) disable iff (!rst_n) priv != priv_s)
        else begin
            $error("privilege mode reached supervisor");
            assert_fails++;
        end

endmodule

bind csr_unit csr_unit_chk u_chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd_data    (rd_data),
    .illegal    (illegal),
    .interrupts (interrupts),
    .priv       (priv)
);

// File: tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int period      = 20,
    parameter int reset_cycles = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // release a little after the edge, like every other input
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #2;
        rst_n = 1'b1;
    end

endmodule

// File: tb_csr_unit.sv
`timescale 1ns/1ps

module tb_csr_unit;
    import csr_pkg::*;

    localparam int clk_period  = 20;
    // reset plus every stimulus cycle below
    localparam int test_cycles = 170;
    localparam int tb_hart_id  = 5;

    typedef struct packed {
        word_t rd_data;
        logic  illegal;
        word_t interrupts;
    } expect_t;

    logic       clk;
    logic       rst_n;
    csr_write_t wr;
    logic       retire;
    trap_req_t  trap;
    csr_addr_t  rd_addr;
    logic       mtime_interrupt;
    word_t      int_sources;
    word_t      rd_data;
    logic       illegal;
    word_t      interrupts;
    word_t      mepc_out;
    word_t      mtvec_out;

    integer seed   = 32'h41cb_d9de;
    int     errors = 0;

    // last entry is an unused address
    csr_addr_t id_addrs [7] = '{csr_mstatus, csr_misa, csr_mvendorid, csr_marchid,
                                csr_mimpid, csr_mhartid, 12'h7c0};

    // shadow state
    priv_mode_t  ref_priv;
    priv_mode_t  ref_mpp;
    logic        ref_mpie;
    logic        ref_smie;
    word_t       ref_mtvec;
    word_t       ref_mepc;
    word_t       ref_mcause;
    word_t       ref_mtval;
    word_t       ref_mscratch;
    word_t       ref_ie_mask;
    logic [15:0] ref_pend;
    logic [63:0] ref_mcycle;
    logic [63:0] ref_minstret;
    logic        ref_cy_inh;
    logic        ref_ir_inh;

    tb_clk_gen #(.period(clk_period), .reset_cycles(8)) u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    csr_unit #(.hart_id(tb_hart_id)) dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .wr              (wr),
        .retire          (retire),
        .trap            (trap),
        .rd_addr         (rd_addr),
        .mtime_interrupt (mtime_interrupt),
        .int_sources     (int_sources),
        .rd_data         (rd_data),
        .illegal         (illegal),
        .interrupts      (interrupts),
        .mepc            (mepc_out),
        .mtvec           (mtvec_out)
    );

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////
    function automatic expect_t expected_outputs(input csr_addr_t addr);
        expect_t e;
        word_t   mip_w;
        word_t   data;
        logic    known;
        logic    any_mode;
        mip_w    = {ref_pend, 16'h0000};
        mip_w[7] = mtime_interrupt;
        known    = 1'b1;
        data     = '0;
        any_mode = addr == csr_cycle || addr == csr_cycleh
                || addr == csr_instret || addr == csr_instreth;
        case (addr)
            csr_cycle, csr_mcycle:      data = ref_mcycle[31:0];
            csr_cycleh, csr_mcycleh:    data = ref_mcycle[63:32];
            csr_instret, csr_minstret:  data = ref_minstret[31:0];
            csr_instreth, csr_minstreth: data = ref_minstret[63:32];
            csr_misa:          data = 32'h4000_0100;
            csr_mvendorid:     data = '0;
            csr_marchid:       data = '0;
            csr_mimpid:        data = 32'd2;
            csr_mhartid:       data = tb_hart_id;
            csr_mstatus:       data = {19'b0, ref_mpp, 3'b0, ref_mpie, 3'b0, ref_smie, 3'b0};
            csr_mtvec:         data = ref_mtvec;
            csr_mip:           data = mip_w;
            csr_mie:           data = ref_ie_mask;
            csr_mscratch:      data = ref_mscratch;
            csr_mepc:          data = ref_mepc;
            csr_mcause:        data = ref_mcause;
            csr_mtval:         data = ref_mtval;
            csr_mcountinhibit: data = {29'b0, ref_ir_inh, 1'b0, ref_cy_inh};
            default:           known = 1'b0;
        endcase
        if (!rst_n) begin
            e = '0;
        end else begin
            e.illegal = !(known && (any_mode || ref_priv == priv_m));
            e.rd_data = e.illegal ? '0 : data;
            // m mode needs mstatus.mie, u mode always sees enabled sources
            if (ref_priv == priv_m && !ref_smie) begin
                e.interrupts = '0;
            end else begin
                e.interrupts = mip_w & ref_ie_mask;
            end
        end
        return e;
    endfunction

    // next state from the inputs that the coming edge will see
    task automatic update_model();
        logic       wr_ok;
        priv_mode_t old_priv;
        priv_mode_t old_mpp;
        logic       old_mpie;
        logic       old_smie;
        if (!rst_n) begin
            ref_priv     = priv_m;
            ref_mpp      = priv_u;
            ref_mpie     = 1'b1;
            ref_smie     = 1'b1;
            ref_mtvec    = '0;
            ref_mepc     = '0;
            ref_mcause   = '0;
            ref_mtval    = '0;
            ref_mscratch = '0;
            ref_ie_mask  = '0;
            ref_pend     = '0;
            ref_mcycle   = '0;
            ref_minstret = '0;
            ref_cy_inh   = 1'b0;
            ref_ir_inh   = 1'b0;
        end else begin
            old_priv = ref_priv;
            old_mpp  = ref_mpp;
            old_mpie = ref_mpie;
            old_smie = ref_smie;
            wr_ok    = wr.en && retire && ref_priv == priv_m;

            if (wr_ok && wr.addr == csr_mcycle) ref_mcycle[31:0] = wr.data;
            else if (wr_ok && wr.addr == csr_mcycleh) ref_mcycle[63:32] = wr.data;
            else if (!ref_cy_inh) ref_mcycle = ref_mcycle + 64'd1;

            if (wr_ok && wr.addr == csr_minstret) ref_minstret[31:0] = wr.data;
            else if (wr_ok && wr.addr == csr_minstreth) ref_minstret[63:32] = wr.data;
            else if (retire && !ref_ir_inh) ref_minstret = ref_minstret + 64'd1;

            ref_pend = ((wr_ok && wr.addr == csr_mip) ? wr.data[31:16] : ref_pend)
                     | int_sources[31:16];

            if (wr_ok) begin
                case (wr.addr)
                    csr_mcountinhibit: begin
                        ref_cy_inh = wr.data[0];
                        ref_ir_inh = wr.data[2];
                    end
                    csr_mstatus: begin
                        ref_mpp  = (wr.data[12:11] == 2'd3) ? priv_m : priv_u;
                        ref_mpie = wr.data[7];
                        ref_smie = wr.data[3];
                    end
                    csr_mtvec: ref_mtvec = (wr.data[1:0] == 2'd1)
                                         ? {wr.data[31:7], 7'h01} : {wr.data[31:2], 2'b00};
                    csr_mie:      ref_ie_mask  = wr.data & 32'hffff_0080;
                    csr_mepc:     ref_mepc     = {wr.data[31:2], 2'b00};
                    csr_mcause:   ref_mcause   = wr.data;
                    csr_mtval:    ref_mtval    = wr.data;
                    csr_mscratch: ref_mscratch = wr.data;
                    default: ;
                endcase
            end

            // trap and mret win over a write in the same cycle
            if (trap.insert && trap.is_mret) begin
                ref_priv = old_mpp;
                ref_smie = old_mpie;
                ref_mpie = 1'b1;
                ref_mpp  = priv_u;
            end else if (trap.insert) begin
                ref_priv   = priv_m;
                ref_mpie   = old_smie;
                ref_smie   = 1'b0;
                ref_mpp    = old_priv;
                ref_mepc   = trap.epc;
                ref_mcause = trap.cause;
                ref_mtval  = trap.val;
            end
        end
    endtask

    task automatic check(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // sample 1 ns before each rising edge, then advance the model
    initial begin : compare_outputs
        expect_t exp_v;
        forever begin
            @(negedge clk);
            #(clk_period / 2 - 1);
            exp_v = expected_outputs(rd_addr);
            check(rd_data, exp_v.rd_data, "rd_data");
            check({31'b0, illegal}, {31'b0, exp_v.illegal}, "illegal");
            check(interrupts, exp_v.interrupts, "interrupts");
            if (rst_n) begin
                check(mepc_out, ref_mepc, "mepc port");
                check(mtvec_out, ref_mtvec, "mtvec port");
            end
            update_model();
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////////////////////////
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // write, then read the same address back in the following cycle
    task automatic write_csr(input csr_addr_t addr, input word_t data);
        wr     = '{en: 1'b1, addr: addr, data: data};
        retire = 1'b1;
        next_cycle();
        wr.en   = 1'b0;
        rd_addr = addr;
        next_cycle();
    endtask

    task automatic read_now(input csr_addr_t addr, output word_t data);
        rd_addr = addr;
        #1;
        data = rd_data;
    endtask

    task automatic send_trap(input logic mret, input word_t epc, input word_t cause,
                             input word_t val);
        trap = '{insert: 1'b1, is_mret: mret, epc: epc, cause: cause, val: val};
        next_cycle();
        trap.insert = 1'b0;
    endtask

    initial begin : stimulus
        word_t      c0;
        word_t      c1;
        word_t      d;
        logic [1:0] mode;
        wr              = '0;
        retire          = 1'b0;
        trap            = '0;
        rd_addr         = csr_mstatus;
        mtime_interrupt = 1'b0;
        int_sources     = '0;
        wait (rst_n);

        // reset values and identification
        foreach (id_addrs[k]) begin
            rd_addr = id_addrs[k];
            next_cycle();
        end
        read_now(csr_mhartid, d);
        check(d, 32'd5, "mhartid");

        // legalized writes
        for (int i = 0; i < 4; i++) begin
            write_csr(csr_mscratch, $random(seed));
            write_csr(csr_mcause, $random(seed));
            write_csr(csr_mtval, $random(seed));
            write_csr(csr_mepc, $random(seed));
            d    = $random(seed);
            mode = i[1:0];
            write_csr(csr_mtvec, {d[31:2], mode});
        end
        wr     = '{en: 1'b1, addr: csr_mscratch, data: 32'hdead_beef};
        retire = 1'b0;
        next_cycle();
        wr.en  = 1'b0;
        retire = 1'b1;
        rd_addr = csr_mscratch;
        next_cycle();

        // counters
        read_now(csr_mcycle, c0);
        repeat (10) next_cycle();
        read_now(csr_mcycle, c1);
        check(c1 - c0, 32'd10, "mcycle delta");
        rd_addr = csr_minstret;
        for (int i = 0; i < 16; i++) begin
            d      = $random(seed);
            retire = d[0];
            next_cycle();
        end
        retire = 1'b1;
        write_csr(csr_mcountinhibit, 32'h0000_0005);
        read_now(csr_mcycle, c0);
        repeat (6) next_cycle();
        read_now(csr_mcycle, c1);
        check(c1 - c0, 32'd0, "inhibited mcycle delta");
        rd_addr = csr_minstret;
        repeat (3) next_cycle();
        write_csr(csr_mcountinhibit, 32'h0);
        write_csr(csr_mcycleh, $random(seed));
        write_csr(csr_minstreth, $random(seed));
        write_csr(csr_minstret, 32'hffff_fff0);
        rd_addr = csr_minstreth;
        repeat (20) next_cycle();

        // trap from m while an mepc write collides
        d       = $random(seed);
        rd_addr = csr_mstatus;
        wr      = '{en: 1'b1, addr: csr_mepc, data: 32'h1234_5678};
        send_trap(1'b0, {d[31:2], 2'b00}, 32'd11, $random(seed));
        wr.en   = 1'b0;
        rd_addr = csr_mepc;
        next_cycle();
        rd_addr = csr_mcause;
        next_cycle();
        rd_addr = csr_mtval;
        next_cycle();

        // drop to u mode by mret
        write_csr(csr_mstatus, 32'h0000_0080);
        send_trap(1'b1, '0, '0, '0);
        rd_addr = csr_mscratch;
        next_cycle();
        rd_addr = csr_cycle;
        next_cycle();
        write_csr(csr_mscratch, 32'hffff_ffff);

        // second trap brings m back with mpp u
        send_trap(1'b0, 32'h0000_0100, 32'd2, '0);
        rd_addr = csr_mstatus;
        next_cycle();
        rd_addr = csr_mscratch;
        next_cycle();

        //////////////////////////////////////////////////////////////////////
        // interrupts
        //////////////////////////////////////////////////////////////////////
        write_csr(csr_mie, 32'hffff_0080);
        mtime_interrupt = 1'b1;
        rd_addr = csr_mip;
        repeat (3) next_cycle();
        write_csr(csr_mstatus, 32'h0000_0008);
        repeat (2) next_cycle();
        write_csr(csr_mstatus, 32'h0);
        send_trap(1'b1, '0, '0, '0);
        repeat (3) next_cycle();
        mtime_interrupt = 1'b0;
        for (int i = 0; i < 6; i++) begin
            d           = $random(seed);
            int_sources = {d[31:16], 16'h0000};
            next_cycle();
            int_sources = '0;
            next_cycle();
        end
        send_trap(1'b0, 32'h0000_0200, 32'd7, '0);
        rd_addr = csr_mip;
        repeat (2) next_cycle();
        write_csr(csr_mip, 32'h0);
        repeat (2) next_cycle();

        $display("%0d errors, %0d assertion failures", errors, dut.u_chk.assert_fails);
        if (errors == 0 && dut.u_chk.assert_fails == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin : watchdog
        #((test_cycles + 100) * clk_period);
        $display("simulation timed out after %0d cycles", test_cycles + 100);
        $display("Regression failed");
        $finish;
    end

endmodule

// File: all.f
csr_pkg.sv
csr_counters.sv
csr_trap_state.sv
csr_interrupts.sv
csr_read_mux.sv
csr_unit.sv
csr_unit_chk.sv
tb_clk_gen.sv
tb_csr_unit.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_csr_unit -Mdir obj_dir -o sim
./obj_dir/sim +verilator+error+limit+100 | tee sim.log

if grep -q "^Regression passed$" sim.log; then
    exit 0
fi
exit 1
